// ==== source/mips_decode_macros.svh ====
// Datapath widths, register count, opcodes, funct codes and ALU control codes
`ifndef MIPS_DECODE_MACROS_SVH
`define MIPS_DECODE_MACROS_SVH

`define MIPS_WORD_W        32
`define MIPS_REG_ADDR_W    5
`define MIPS_NUM_REGS      32

// Primary opcodes, instr[31:26]
`define OP_RTYPE           6'b000000
`define OP_ADDI            6'b001000
`define OP_SLTI            6'b001010
`define OP_LW              6'b100011
`define OP_SW              6'b101011
`define OP_BEQ             6'b000100
`define OP_BNE             6'b000101
`define OP_J               6'b000010

// R-type funct, instr[5:0]
`define FN_ADD             6'b100000
`define FN_SUB             6'b100010
`define FN_AND             6'b100100
`define FN_OR              6'b100101
`define FN_SLT             6'b101010

// ALU control codes seen by EX
`define ALU_AND            4'b0000
`define ALU_OR             4'b0001
`define ALU_ADD            4'b0010
`define ALU_SUB            4'b0110
`define ALU_SLT            4'b0111

`endif

// ==== source/mips_decode_pkg.sv ====
// Shared vector typedefs and packed structs for the decode stage
package mips_decode_pkg;

    `include "mips_decode_macros.svh"

    typedef logic [`MIPS_WORD_W-1:0]     word_t;      // Data or address word
    typedef logic [`MIPS_REG_ADDR_W-1:0] reg_addr_t;  // Register index
    typedef logic [3:0]                  alu_ctrl_t;  // ALU operation code

    // 13-bit control bundle carried from ID into EX
    typedef struct packed {
        logic      reg_write;   // W stage writes the register file
        logic      mem_to_reg;  // Write-back source is memory
        logic      mem_read;
        logic      mem_write;
        logic      alu_src;     // ALU operand b is the immediate
        logic      reg_dst;     // Destination is rd, not rt
        alu_ctrl_t alu_ctrl;
        logic      branch;
        logic      equal;       // 1 for beq, 0 for bne
        logic      jump;
    } ctrl_t;

    // Write-back port coming from W
    typedef struct packed {
        logic      reg_write;
        reg_addr_t dest;
        word_t     data;
    } wb_port_t;

    // M stage result seen by the early branch compare
    typedef struct packed {
        logic      reg_write;
        reg_addr_t dest;
        word_t     alu_result;
    } mem_fwd_t;

    // ID/EX pipeline register contents
    typedef struct packed {
        ctrl_t     ctrl;
        word_t     read_data_1;
        word_t     read_data_2;
        word_t     imm;         // Sign-extended immediate
        word_t     npc;
        reg_addr_t rs;
        reg_addr_t rt;
        reg_addr_t rd;
    } id_ex_t;

endpackage

// ==== source/decode_control.sv ====
// Main control decoder with stall bubbling for the decode stage
`timescale 1ns/100ps

`include "mips_decode_macros.svh"

module decode_control
    import mips_decode_pkg::*;
(
    input  word_t i_instr,   // Instruction in ID
    input  logic  i_stall,   // Hazard detector stall request
    output ctrl_t o_ctrl     // Decoded control or zero under stall
);

    logic [5:0] opcode;
    logic [5:0] funct;
    ctrl_t      ctrl_dec;

    assign opcode = i_instr[31:26];
    assign funct  = i_instr[5:0];

    always_comb begin
        ctrl_dec = '0;  // Unknown opcodes fall out as all zero
        case (opcode)
            `OP_RTYPE: begin
                ctrl_dec.reg_write = 1'b1;
                ctrl_dec.reg_dst   = 1'b1;
                case (funct)
                    `FN_ADD: ctrl_dec.alu_ctrl = `ALU_ADD;
                    `FN_SUB: ctrl_dec.alu_ctrl = `ALU_SUB;
                    `FN_AND: ctrl_dec.alu_ctrl = `ALU_AND;
                    `FN_OR:  ctrl_dec.alu_ctrl = `ALU_OR;
                    `FN_SLT: ctrl_dec.alu_ctrl = `ALU_SLT;
                    default: ctrl_dec = '0;  // Unsupported funct has no side effects
                endcase
            end
            `OP_ADDI: begin
                ctrl_dec.reg_write = 1'b1;
                ctrl_dec.alu_src   = 1'b1;
                ctrl_dec.alu_ctrl  = `ALU_ADD;
            end
            `OP_SLTI: begin
                ctrl_dec.reg_write = 1'b1;
                ctrl_dec.alu_src   = 1'b1;
                ctrl_dec.alu_ctrl  = `ALU_SLT;
            end
            `OP_LW: begin
                ctrl_dec.reg_write  = 1'b1;
                ctrl_dec.mem_to_reg = 1'b1;
                ctrl_dec.mem_read   = 1'b1;
                ctrl_dec.alu_src    = 1'b1;
                ctrl_dec.alu_ctrl   = `ALU_ADD;  // Base plus offset
            end
            `OP_SW: begin
                ctrl_dec.mem_write = 1'b1;
                ctrl_dec.alu_src   = 1'b1;
                ctrl_dec.alu_ctrl  = `ALU_ADD;
            end
            `OP_BEQ: begin
                ctrl_dec.branch   = 1'b1;
                ctrl_dec.equal    = 1'b1;
                ctrl_dec.alu_ctrl = `ALU_SUB;
            end
            `OP_BNE: begin
                ctrl_dec.branch   = 1'b1;
                ctrl_dec.alu_ctrl = `ALU_SUB;
            end
            `OP_J: begin
                ctrl_dec.jump = 1'b1;
            end
            default: ctrl_dec = '0;
        endcase
    end

    // A stalled instruction becomes a bubble with branch and jump dropped
    assign o_ctrl = i_stall ? ctrl_t'('0) : ctrl_dec;

endmodule

// ==== source/register_file.sv ====
// 32-entry register file, two reads with write-through, one write, zero register
`timescale 1ns/100ps

`include "mips_decode_macros.svh"

module register_file
    import mips_decode_pkg::*;
(
    input  logic      i_clk,
    input  logic      i_rst,
    input  reg_addr_t i_rs,        // Read address 1
    input  reg_addr_t i_rt,        // Read address 2
    input  wb_port_t  i_wb,        // Write port from W
    output word_t     o_rs_data,
    output word_t     o_rt_data
);

    word_t regs [`MIPS_NUM_REGS];
    logic  wr_en;

    // Writes to r0 are dropped
    assign wr_en = i_wb.reg_write && (i_wb.dest != '0);

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            for (int i = 0; i < `MIPS_NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en) begin
            regs[i_wb.dest] <= i_wb.data;
        end
    end

    // Same-cycle write is returned on the read side
    function automatic word_t read_port(input reg_addr_t addr);
        word_t data;
        if (addr == '0)
            data = '0;
        else if (wr_en && (i_wb.dest == addr))
            data = i_wb.data;
        else
            data = regs[addr];
        return data;
    endfunction

    always_comb begin
        o_rs_data = read_port(i_rs);
        o_rt_data = read_port(i_rt);
    end

endmodule

// ==== source/eq_forward_unit.sv ====
// Forwarding selects for the branch equality operands
`timescale 1ns/100ps

module eq_forward_unit
    import mips_decode_pkg::*;
(
    input  reg_addr_t i_rs,
    input  reg_addr_t i_rt,
    input  mem_fwd_t  i_mem_fwd,   // Result sitting in M
    output logic      o_fwd_a,     // Take M result for operand a
    output logic      o_fwd_b      // Take M result for operand b
);

    logic mem_valid;

    // M forwards only a real register write to a nonzero register
    assign mem_valid = i_mem_fwd.reg_write && (i_mem_fwd.dest != '0);

    assign o_fwd_a = mem_valid && (i_mem_fwd.dest == i_rs);
    assign o_fwd_b = mem_valid && (i_mem_fwd.dest == i_rt);

endmodule

// ==== source/branch_unit.sv ====
// Forwarding muxes, equality compare, branch decision, immediate and targets
`timescale 1ns/100ps

`include "mips_decode_macros.svh"

module branch_unit
    import mips_decode_pkg::*;
(
    input  word_t    i_instr,
    input  word_t    i_npc,
    input  word_t    i_rs_data,      // Register file read 1
    input  word_t    i_rt_data,      // Register file read 2
    input  mem_fwd_t i_mem_fwd,
    input  logic     i_fwd_a,
    input  logic     i_fwd_b,
    input  ctrl_t    i_ctrl,
    output word_t    o_op_a,         // Forwarded operand a
    output word_t    o_op_b,         // Forwarded operand b
    output word_t    o_imm,          // Sign-extended immediate
    output logic     o_pc_src,       // Taken branch
    output logic     o_jump,
    output word_t    o_branch_addr,
    output word_t    o_jump_addr
);

    logic  operands_eq;
    word_t imm_shifted;

    assign o_op_a = i_fwd_a ? i_mem_fwd.alu_result : i_rs_data;
    assign o_op_b = i_fwd_b ? i_mem_fwd.alu_result : i_rt_data;

    assign operands_eq = (o_op_a == o_op_b);

    // beq takes on equal, bne on unequal
    assign o_pc_src = i_ctrl.branch && (operands_eq == i_ctrl.equal);
    assign o_jump   = i_ctrl.jump;   // Already cleared by a stall

    assign o_imm = {{(`MIPS_WORD_W-16){i_instr[15]}}, i_instr[15:0]};

    // Word offset relative to the next PC
    assign imm_shifted   = o_imm << 2;
    assign o_branch_addr = i_npc + imm_shifted;

    // Region bits from npc, word index from the instruction
    assign o_jump_addr = {i_npc[31:28], i_instr[25:0], 2'b00};

endmodule

// ==== source/id_ex_register.sv ====
// ID/EX pipeline register holding control, operands, immediate and register fields
`timescale 1ns/100ps

module id_ex_register
    import mips_decode_pkg::*;
(
    input  logic   i_clk,
    input  logic   i_rst,
    input  ctrl_t  i_ctrl,     // Zero when ID was stalled
    input  word_t  i_op_a,
    input  word_t  i_op_b,
    input  word_t  i_imm,
    input  word_t  i_npc,
    input  word_t  i_instr,
    output id_ex_t o_id_ex
);

    id_ex_t    id_ex_d;
    reg_addr_t rs;
    reg_addr_t rt;
    reg_addr_t rd;

    assign rs = i_instr[25:21];
    assign rt = i_instr[20:16];
    assign rd = i_instr[15:11];  // Only meaningful for R-type

    always_comb begin
        id_ex_d             = '0;
        id_ex_d.ctrl        = i_ctrl;
        id_ex_d.read_data_1 = i_op_a;
        id_ex_d.read_data_2 = i_op_b;
        id_ex_d.imm         = i_imm;
        id_ex_d.npc         = i_npc;
        id_ex_d.rs          = rs;
        id_ex_d.rt          = rt;
        id_ex_d.rd          = rd;
    end

    // Control of a stall bubble arrives already zero
    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            o_id_ex <= '0;
        end else begin
            o_id_ex <= id_ex_d;
        end
    end

endmodule

// ==== source/decode_stage.sv ====
// Decode stage top level connecting control, register file, forwarding, branch and ID/EX
`timescale 1ns/100ps

module decode_stage
    import mips_decode_pkg::*;
(
    input  logic     i_clk,
    input  logic     i_rst,
    input  word_t    i_instr,        // Fetched instruction
    input  word_t    i_npc,          // PC + 4 of that instruction
    input  logic     i_stall,        // From the load-use hazard detector
    input  wb_port_t i_wb,           // W stage write-back
    input  mem_fwd_t i_mem_fwd,      // M stage forwarding view
    output id_ex_t   o_id_ex,
    output logic     o_pc_src,
    output logic     o_jump,
    output word_t    o_branch_addr,
    output word_t    o_jump_addr
);

    ctrl_t     ctrl;
    reg_addr_t rs;
    reg_addr_t rt;
    word_t     rs_data;
    word_t     rt_data;
    logic      fwd_a;
    logic      fwd_b;
    word_t     op_a;
    word_t     op_b;
    word_t     imm;

    assign rs = i_instr[25:21];
    assign rt = i_instr[20:16];

    decode_control u_decode_control (
        .i_instr (i_instr),
        .i_stall (i_stall),
        .o_ctrl  (ctrl)
    );

    register_file u_register_file (
        .i_clk     (i_clk),
        .i_rst     (i_rst),
        .i_rs      (rs),
        .i_rt      (rt),
        .i_wb      (i_wb),
        .o_rs_data (rs_data),
        .o_rt_data (rt_data)
    );

    eq_forward_unit u_eq_forward_unit (
        .i_rs      (rs),
        .i_rt      (rt),
        .i_mem_fwd (i_mem_fwd),
        .o_fwd_a   (fwd_a),
        .o_fwd_b   (fwd_b)
    );

    branch_unit u_branch_unit (
        .i_instr       (i_instr),
        .i_npc         (i_npc),
        .i_rs_data     (rs_data),
        .i_rt_data     (rt_data),
        .i_mem_fwd     (i_mem_fwd),
        .i_fwd_a       (fwd_a),
        .i_fwd_b       (fwd_b),
        .i_ctrl        (ctrl),
        .o_op_a        (op_a),
        .o_op_b        (op_b),
        .o_imm         (imm),
        .o_pc_src      (o_pc_src),
        .o_jump        (o_jump),
        .o_branch_addr (o_branch_addr),
        .o_jump_addr   (o_jump_addr)
    );

    id_ex_register u_id_ex_register (
        .i_clk   (i_clk),
        .i_rst   (i_rst),
        .i_ctrl  (ctrl),
        .i_op_a  (op_a),
        .i_op_b  (op_b),
        .i_imm   (imm),
        .i_npc   (i_npc),
        .i_instr (i_instr),
        .o_id_ex (o_id_ex)
    );

endmodule

// ==== testbench/decode_checker.sv ====
// Reference model of the decode stage and comparison of its outputs, with error counts
`timescale 1ns/100ps

`include "mips_decode_macros.svh"

module decode_checker
    import mips_decode_pkg::*;
(
    input  logic     i_clk,
    input  logic     i_rst,
    input  word_t    i_instr,
    input  word_t    i_npc,
    input  logic     i_stall,
    input  wb_port_t i_wb,
    input  mem_fwd_t i_mem_fwd,
    input  id_ex_t   i_id_ex,
    input  logic     i_pc_src,
    input  logic     i_jump,
    input  word_t    i_branch_addr,
    input  word_t    i_jump_addr,
    output int       o_error_count,
    output int       o_check_count
);

    word_t  model_regs [32];
    id_ex_t expected;               // ID/EX value due after the next edge
    logic   expected_valid = 1'b0;
    int     errors = 0;
    int     checks = 0;
    word_t  op_a;
    word_t  op_b;
    word_t  imm;
    logic   taken;

    assign o_error_count = errors;
    assign o_check_count = checks;

    // Field order is reg_write mem_to_reg mem_read mem_write alu_src reg_dst alu branch equal jump
    function automatic ctrl_t model_ctrl(input word_t instr, input logic stall);
        logic [3:0] alu;
        logic       known;
        ctrl_t      c;
        known = 1'b1;
        alu   = 4'b0000;
        case (instr[5:0])
            `FN_ADD: alu = `ALU_ADD;
            `FN_SUB: alu = `ALU_SUB;
            `FN_AND: alu = `ALU_AND;
            `FN_OR:  alu = `ALU_OR;
            `FN_SLT: alu = `ALU_SLT;
            default: known = 1'b0;
        endcase
        case (instr[31:26])
            `OP_RTYPE: c = known ? {6'b100001, alu, 3'b000} : '0;
            `OP_ADDI:  c = {6'b100010, `ALU_ADD, 3'b000};
            `OP_SLTI:  c = {6'b100010, `ALU_SLT, 3'b000};
            `OP_LW:    c = {6'b111010, `ALU_ADD, 3'b000};
            `OP_SW:    c = {6'b000110, `ALU_ADD, 3'b000};
            `OP_BEQ:   c = {6'b000000, `ALU_SUB, 3'b110};
            `OP_BNE:   c = {6'b000000, `ALU_SUB, 3'b100};
            `OP_J:     c = {6'b000000, 4'b0000, 3'b001};
            default:   c = '0;
        endcase
        return stall ? ctrl_t'('0) : c;
    endfunction

    // Register read in the current cycle including write-back
    function automatic word_t read_model(input reg_addr_t addr);
        if (addr == 5'd0)
            return '0;
        if (i_wb.reg_write && i_wb.dest == addr)
            return i_wb.data;
        return model_regs[addr];
    endfunction

    function automatic word_t operand(input reg_addr_t addr);
        if (i_mem_fwd.reg_write && i_mem_fwd.dest != 5'd0 && i_mem_fwd.dest == addr)
            return i_mem_fwd.alu_result;
        return read_model(addr);
    endfunction

    task automatic check(input string what, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAIL %0t: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    // Sampled mid-cycle, away from the drive edge
    always @(negedge i_clk) begin
        if (expected_valid) begin
            check("id_ex.ctrl", 32'(i_id_ex.ctrl), 32'(expected.ctrl));
            check("id_ex.read_data_1", i_id_ex.read_data_1, expected.read_data_1);
            check("id_ex.read_data_2", i_id_ex.read_data_2, expected.read_data_2);
            check("id_ex.imm", i_id_ex.imm, expected.imm);
            check("id_ex.npc", i_id_ex.npc, expected.npc);
            check("id_ex.rs/rt/rd", 32'({i_id_ex.rs, i_id_ex.rt, i_id_ex.rd}),
                  32'({expected.rs, expected.rt, expected.rd}));
        end
        if (i_rst) begin
            for (int r = 0; r < 32; r++)
                model_regs[r] = '0;
            expected       = '0;
            expected_valid = 1'b1;
        end else begin
            op_a  = operand(i_instr[25:21]);
            op_b  = operand(i_instr[20:16]);
            imm   = word_t'($signed(i_instr[15:0]));
            taken = !i_stall && ((i_instr[31:26] == `OP_BEQ && op_a == op_b) ||
                                 (i_instr[31:26] == `OP_BNE && op_a != op_b));
            check("o_pc_src", 32'(i_pc_src), 32'(taken));
            check("o_jump", 32'(i_jump), 32'(!i_stall && i_instr[31:26] == `OP_J));
            check("o_branch_addr", i_branch_addr, i_npc + imm * 32'd4);
            check("o_jump_addr", i_jump_addr,
                  (i_npc & 32'hf000_0000) | (32'(i_instr[25:0]) * 32'd4));
            expected.ctrl        = model_ctrl(i_instr, i_stall);
            expected.read_data_1 = op_a;
            expected.read_data_2 = op_b;
            expected.imm         = imm;
            expected.npc         = i_npc;
            expected.rs          = i_instr[25:21];
            expected.rt          = i_instr[20:16];
            expected.rd          = i_instr[15:11];
            expected_valid       = 1'b1;
            if (i_wb.reg_write && i_wb.dest != 5'd0)
                model_regs[i_wb.dest] = i_wb.data;  // Lands at the coming edge
        end
    end

endmodule

// ==== testbench/tb_decode_stage.sv ====
// Testbench top for the decode stage with clock, reset, stimulus table, drive loop and timeout
`timescale 1ns/100ps

`include "mips_decode_macros.svh"

module tb_decode_stage
    import mips_decode_pkg::*;
();

    // One table row per cycle
    typedef struct packed {
        word_t    instr;
        word_t    npc;
        logic     stall;
        wb_port_t wb;
        mem_fwd_t fwd;
    } stim_t;

    logic     clk = 1'b0;
    logic     rst;
    word_t    instr;
    word_t    npc;
    logic     stall;
    wb_port_t wb;
    mem_fwd_t mem_fwd;
    id_ex_t   id_ex;
    logic     pc_src;
    logic     jump;
    word_t    branch_addr;
    word_t    jump_addr;
    int       error_count;
    int       check_count;

    stim_t    rows[$];
    word_t    reg_vals [32];        // Written values used to build equal operands
    integer   seed;
    int       cycle_count = 0;
    int       timeout_limit = 0;

    decode_stage dut0 (
        .i_clk         (clk),
        .i_rst         (rst),
        .i_instr       (instr),
        .i_npc         (npc),
        .i_stall       (stall),
        .i_wb          (wb),
        .i_mem_fwd     (mem_fwd),
        .o_id_ex       (id_ex),
        .o_pc_src      (pc_src),
        .o_jump        (jump),
        .o_branch_addr (branch_addr),
        .o_jump_addr   (jump_addr)
    );

    decode_checker checker0 (
        .i_clk         (clk),
        .i_rst         (rst),
        .i_instr       (instr),
        .i_npc         (npc),
        .i_stall       (stall),
        .i_wb          (wb),
        .i_mem_fwd     (mem_fwd),
        .i_id_ex       (id_ex),
        .i_pc_src      (pc_src),
        .i_jump        (jump),
        .i_branch_addr (branch_addr),
        .i_jump_addr   (jump_addr),
        .o_error_count (error_count),
        .o_check_count (check_count)
    );

    always #10 clk = ~clk;  // 20 ns period

    function automatic word_t r_type(input reg_addr_t rs, input reg_addr_t rt,
                                     input reg_addr_t rd, input logic [5:0] funct);
        return {`OP_RTYPE, rs, rt, rd, 5'd0, funct};
    endfunction

    function automatic word_t i_type(input logic [5:0] op, input reg_addr_t rs,
                                     input reg_addr_t rt, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic wb_port_t wb_of(input reg_addr_t dest, input word_t data);
        wb_port_t w;
        w.reg_write = 1'b1;
        w.dest      = dest;
        w.data      = data;
        return w;
    endfunction

    function automatic mem_fwd_t fwd_of(input logic we, input reg_addr_t dest, input word_t data);
        mem_fwd_t f;
        f.reg_write  = we;
        f.dest       = dest;
        f.alu_result = data;
        return f;
    endfunction

    task automatic add_row_npc(input word_t instr_v, input word_t npc_v, input logic stall_v,
                               input wb_port_t wb_v, input mem_fwd_t fwd_v);
        stim_t row;
        row.instr = instr_v;
        row.npc   = npc_v;
        row.stall = stall_v;
        row.wb    = wb_v;
        row.fwd   = fwd_v;
        rows.push_back(row);
    endtask

    task automatic add_row(input word_t instr_v, input logic stall_v,
                           input wb_port_t wb_v, input mem_fwd_t fwd_v);
        add_row_npc(instr_v, 32'h0040_0004 + 32'(rows.size() * 4), stall_v, wb_v, fwd_v);
    endtask

    task automatic build_table();
        word_t data;
        for (int i = 0; i < 16; i++)  // Every register reads zero after reset
            add_row(r_type(5'(2 * i), 5'(2 * i + 1), 5'd1, `FN_ADD), 1'b0, '0, '0);
        for (int r = 1; r < 32; r++) begin
            data        = $random(seed);
            reg_vals[r] = data;
            // rs hits the write in flight, rt the one before it
            add_row(r_type(5'(r), 5'(r - 1), 5'(r), `FN_ADD), 1'b0, wb_of(5'(r), data), '0);
        end
        data = $random(seed);
        add_row(r_type(5'd0, 5'd0, 5'd2, `FN_OR), 1'b0, wb_of(5'd0, data), '0);
        for (int i = 1; i <= 16; i++)
            add_row(r_type(5'(i), 5'(32 - i), 5'd3, `FN_AND), 1'b0, '0, '0);
        // Control decode
        add_row(r_type(5'd1, 5'd2, 5'd3, `FN_ADD), 1'b0, '0, '0);
        add_row(r_type(5'd1, 5'd2, 5'd3, `FN_SUB), 1'b0, '0, '0);
        add_row(r_type(5'd4, 5'd5, 5'd6, `FN_AND), 1'b0, '0, '0);
        add_row(r_type(5'd4, 5'd5, 5'd6, `FN_OR), 1'b0, '0, '0);
        add_row(r_type(5'd7, 5'd8, 5'd9, `FN_SLT), 1'b0, '0, '0);
        add_row(r_type(5'd7, 5'd8, 5'd9, 6'b000111), 1'b0, '0, '0);  // Unsupported funct
        add_row(i_type(`OP_ADDI, 5'd3, 5'd4, 16'h0123), 1'b0, '0, '0);
        add_row(i_type(`OP_SLTI, 5'd5, 5'd6, 16'hff9c), 1'b0, '0, '0);
        add_row(i_type(`OP_LW, 5'd29, 5'd8, 16'hfffc), 1'b0, '0, '0);
        add_row(i_type(`OP_SW, 5'd29, 5'd9, 16'h7ffc), 1'b0, '0, '0);
        add_row(i_type(6'b001100, 5'd1, 5'd2, 16'h00ff), 1'b0, '0, '0);
        add_row(32'hffff_ffff, 1'b0, '0, '0);
        for (int i = 0; i < 4; i++) begin
            data = $random(seed);
            add_row(i_type(`OP_ADDI, 5'd1, 5'd2, data[15:0]), 1'b0, '0, '0);
        end
        // Plain, forwarded and write-back branches
        add_row(i_type(`OP_BEQ, 5'd4, 5'd4, 16'hfff0), 1'b0, '0, '0);
        add_row(i_type(`OP_BEQ, 5'd4, 5'd5, 16'h0010), 1'b0, '0, '0);
        add_row(i_type(`OP_BNE, 5'd4, 5'd5, 16'h8000), 1'b0, '0, '0);
        add_row(i_type(`OP_BNE, 5'd6, 5'd6, 16'h7fff), 1'b0, '0, '0);
        add_row(i_type(`OP_BEQ, 5'd7, 5'd8, 16'h0004), 1'b0, '0, fwd_of(1'b1, 5'd7, reg_vals[8]));
        add_row(i_type(`OP_BNE, 5'd9, 5'd10, 16'h0008), 1'b0, '0, fwd_of(1'b1, 5'd10, reg_vals[9]));
        add_row(i_type(`OP_BEQ, 5'd7, 5'd8, 16'h000c), 1'b0, '0, fwd_of(1'b0, 5'd7, reg_vals[8]));
        add_row(i_type(`OP_BEQ, 5'd0, 5'd11, 16'h0020), 1'b0, '0, fwd_of(1'b1, 5'd0, reg_vals[11]));
        reg_vals[14] = reg_vals[15];
        add_row(i_type(`OP_BEQ, 5'd14, 5'd15, 16'hffe0), 1'b0, wb_of(5'd14, reg_vals[15]), '0);
        // Jumps with the region bits taken from npc
        add_row_npc({`OP_J, 26'h3ff_ffff}, 32'ha000_0004, 1'b0, '0, '0);
        add_row_npc({`OP_J, 26'h012_3456}, 32'h5000_0000, 1'b0, '0, '0);
        // Stalled cycles become bubbles
        add_row(i_type(`OP_BEQ, 5'd4, 5'd4, 16'h0040), 1'b1, '0, '0);
        add_row({`OP_J, 26'h000_0100}, 1'b1, '0, '0);
        data = $random(seed);
        add_row(i_type(`OP_ADDI, 5'd20, 5'd21, 16'h0001), 1'b1, wb_of(5'd20, data), '0);
        add_row(i_type(`OP_BEQ, 5'd20, 5'd20, 16'h0002), 1'b0, '0, '0);
    endtask

    initial begin
        seed    = 32'h278;
        rst     = 1'b1;
        instr   = '0;
        npc     = '0;
        stall   = 1'b0;
        wb      = '0;
        mem_fwd = '0;
        build_table();
        timeout_limit = rows.size() + 4 + 20;
        repeat (4) @(posedge clk);
        rst <= 1'b0;
        foreach (rows[i]) begin
            @(posedge clk);
            instr   <= rows[i].instr;
            npc     <= rows[i].npc;
            stall   <= rows[i].stall;
            wb      <= rows[i].wb;
            mem_fwd <= rows[i].fwd;
        end
        @(posedge clk);
        instr   <= '0;
        npc     <= '0;
        stall   <= 1'b0;
        wb      <= '0;
        mem_fwd <= '0;
        repeat (3) @(posedge clk);  // Let the last ID/EX value be checked
        $display("Checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0)
            $display("ALL TESTS PASSED");
        else
            $display("SOME TESTS FAILED");
        $finish;
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (timeout_limit > 0 && cycle_count >= timeout_limit) begin
            $display("Simulation timed out after %0d cycles", cycle_count);
            $display("SOME TESTS FAILED");
            $finish;
        end
    end

endmodule

// ==== src.f ====
+incdir+source
source/mips_decode_pkg.sv
source/decode_control.sv
source/register_file.sv
source/eq_forward_unit.sv
source/branch_unit.sv
source/id_ex_register.sv
source/decode_stage.sv
testbench/decode_checker.sv
testbench/tb_decode_stage.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build the decode stage testbench with Verilator, run it and check the log

rm -rf obj_dir sim.log

verilator --binary --timing -j 0 -f src.f --top-module tb_decode_stage -o sim_decode \
    && ./obj_dir/sim_decode | tee sim.log \
    || { echo "Build or simulation run failed"; exit 1; }

grep -q "ALL TESTS PASSED" sim.log \
    && { echo "Simulation passed"; exit 0; } \
    || { echo "Simulation failed"; exit 1; }
